//--- spi_pkg.sv
/*
 * spi_pkg
 * Types for the SPI side of the stream bridge: the data byte,
 * the sclk edge counter and the serial engine states.
 */
package spi_pkg;

	typedef logic [7:0] spi_byte_t;	// one frame payload, msb first on the wire

	// 16 edges per 8-bit frame, needs 0..16
	typedef logic [4:0] bit_cnt_t;

	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,	// cs high or waiting for frame start
		ST_WAIT_EDGE = 3'd1,	// waiting for next sclk transition
		ST_EDGE      = 3'd2,	// act on the transition just seen
		ST_LAST_HALF = 3'd3,	// settle after the 16th edge
		ST_DELIVER   = 3'd4,	// hand the byte over
		ST_FINISH    = 3'd5	// park until cs rises
	} eng_state_t;

endpackage

//--- link_pkg.sv
/*
 * link_pkg
 * Types for the credit links and the two byte fifos next to the engine.
 */
package link_pkg;

	typedef logic [3:0] credit_t;	// up to 15 credits outstanding

	// free-running read/write pointer, low bits index the storage
	typedef logic [2:0] fifo_ptr_t;

	// occupancy, 0..8 entries
	typedef logic [3:0] fifo_cnt_t;

endpackage

//--- spi_frame_if.sv
`timescale 1ns/1ps
/*
 * spi_frame_if
 * Per-frame byte exchange between the SPI engine and the rx and tx buffers.
 */
interface spi_frame_if;

	spi_pkg::spi_byte_t rx_byte;	// byte shifted in from mosi
	logic rx_strobe;	// one cycle, rx_byte valid
	spi_pkg::spi_byte_t tx_byte;	// head of tx fifo
	logic tx_ready;	// tx fifo not empty
	logic tx_take;	// pop head, frame completed

	modport engine (
		output rx_byte,
		output rx_strobe,
		output tx_take,
		input  tx_byte,
		input  tx_ready
	);

	modport rx_side (
		input rx_byte,
		input rx_strobe
	);

	modport tx_side (
		input  tx_take,
		output tx_byte,
		output tx_ready
	);

endinterface

//--- spi_slave.sv
`timescale 1ns/1ps
/*
 * spi_slave
 * Oversampled SPI slave engine, any CPOL/CPHA mode. Per 8-bit frame it
 * shifts one byte in from mosi and one byte out on miso.
 */
module spi_slave #(
	parameter bit                 CPOL    = 1'b1,	// sclk idle level
	parameter bit                 CPHA    = 1'b1,	// 1: sample on trailing edge
	parameter spi_pkg::spi_byte_t TX_FILL = 8'hff	// sent when tx fifo empty
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        cs,	// active low frame select
	input  logic        sclk,
	input  logic        mosi,
	output logic        miso,
	spi_frame_if.engine frm
);

	logic cs_meta;	// two-flop syncs
	logic cs_s;
	logic sclk_meta;
	logic sclk_s;
	logic sclk_d;	// previous synced sclk, for edge detect
	logic mosi_meta;
	logic mosi_s;

	spi_pkg::eng_state_t state;
	spi_pkg::bit_cnt_t   edge_cnt;	// edges done in this frame
	spi_pkg::spi_byte_t  rx_shift;
	spi_pkg::spi_byte_t  tx_shift;
	logic tx_loaded;	// tx_shift came from the fifo, not fill

	logic lead_edge;
	logic trail_edge;
	logic edge_hit;
	logic frame_go;
	logic sample_now;
	logic shift_now;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_meta   <= 1'b1;	// deselected
			cs_s      <= 1'b1;
			sclk_meta <= CPOL;	// idle level
			sclk_s    <= CPOL;
			sclk_d    <= CPOL;
		end else begin
			cs_meta   <= cs;
			cs_s      <= cs_meta;
			sclk_meta <= sclk;
			sclk_s    <= sclk_meta;
			sclk_d    <= sclk_s;
		end
	end

	// mosi is data only, aligned with the sclk sync stages
	always_ff @(posedge sys_clk) begin
		mosi_meta <= mosi;
		mosi_s    <= mosi_meta;
	end

	assign lead_edge  = (sclk_d == CPOL) && (sclk_s != CPOL);	// away from idle
	assign trail_edge = (sclk_d != CPOL) && (sclk_s == CPOL);	// back to idle
	assign edge_hit   = (state == spi_pkg::ST_WAIT_EDGE) &&
		(edge_cnt[0] ? trail_edge : lead_edge);	// even count expects leading edge
	assign frame_go   = (state == spi_pkg::ST_IDLE) && !cs_s;

	// cpha 0 samples even edges, cpha 1 odd ones; miso moves on the others
	assign sample_now = (state == spi_pkg::ST_EDGE) && (edge_cnt[0] == CPHA);
	assign shift_now  = (state == spi_pkg::ST_EDGE) && (edge_cnt[0] != CPHA) &&
		(edge_cnt != 5'd0) && (edge_cnt != 5'd15);	// bit 7 is preloaded

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			state <= spi_pkg::ST_IDLE;
		else if (cs_s)
			state <= spi_pkg::ST_IDLE;	// frame end or abort
		else begin
			case (state)
				spi_pkg::ST_IDLE:
					state <= spi_pkg::ST_WAIT_EDGE;
				spi_pkg::ST_WAIT_EDGE:
					if (edge_hit)
						state <= spi_pkg::ST_EDGE;
				spi_pkg::ST_EDGE:
					if (edge_cnt == 5'd15)
						state <= spi_pkg::ST_LAST_HALF;
					else
						state <= spi_pkg::ST_WAIT_EDGE;
				spi_pkg::ST_LAST_HALF:
					state <= spi_pkg::ST_DELIVER;
				spi_pkg::ST_DELIVER:
					state <= spi_pkg::ST_FINISH;
				spi_pkg::ST_FINISH:
					state <= spi_pkg::ST_FINISH;	// wait for cs rise
				default:
					state <= spi_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			edge_cnt <= '0;
		else if (state == spi_pkg::ST_IDLE)
			edge_cnt <= '0;
		else if (state == spi_pkg::ST_EDGE)
			edge_cnt <= edge_cnt + 5'd1;
	end

	// outgoing byte, loaded at frame start
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			tx_shift  <= '0;	// miso low out of reset
			tx_loaded <= 1'b0;
		end else if (frame_go) begin
			tx_shift  <= frm.tx_ready ? frm.tx_byte : TX_FILL;
			tx_loaded <= frm.tx_ready;
		end else if (shift_now) begin
			tx_shift  <= {tx_shift[6:0], 1'b0};
		end
	end

	// incoming byte, eight samples fill it completely
	always_ff @(posedge sys_clk) begin
		if (sample_now)
			rx_shift <= {rx_shift[6:0], mosi_s};
	end

	assign miso          = tx_shift[7];
	assign frm.rx_byte   = rx_shift;
	assign frm.rx_strobe = (state == spi_pkg::ST_DELIVER);
	// pop only on a complete frame, an aborted one leaves the head queued
	assign frm.tx_take   = (state == spi_pkg::ST_DELIVER) && tx_loaded;

endmodule

//--- rx_credit_fifo.sv
`timescale 1ns/1ps
/*
 * rx_credit_fifo
 * Receive byte buffer. Forwards bytes to the sink while credits remain,
 * drops a byte on a full fifo and latches the overrun flag.
 */
module rx_credit_fifo #(
	parameter int RX_DEPTH   = 4,	// power of two, 2..8
	parameter int RX_CREDITS = 2	// sink credits after reset
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	spi_frame_if.rx_side       frm,
	output spi_pkg::spi_byte_t rx_data,
	output logic               rx_valid,
	input  logic               rx_credit,	// one credit back per pulse
	output logic               rx_overrun	// sticky
);

	localparam int AW = $clog2(RX_DEPTH);

	spi_pkg::spi_byte_t  mem [RX_DEPTH];
	link_pkg::fifo_ptr_t wr_ptr;
	link_pkg::fifo_ptr_t rd_ptr;
	link_pkg::fifo_cnt_t fill;
	link_pkg::credit_t   credits;	// bytes the sink can still take

	logic full;
	logic push;
	logic pop;

	assign full     = (fill == link_pkg::fifo_cnt_t'(RX_DEPTH));
	assign push     = frm.rx_strobe && !full;
	assign rx_valid = (fill != '0) && (credits != '0);	// waits while out of credits
	assign pop      = rx_valid;	// one byte per cycle at most
	assign rx_data  = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge sys_clk) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= frm.rx_byte;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 3'd1;	// depth divides 8, wrap is free
			if (pop)
				rd_ptr <= rd_ptr + 3'd1;
			fill <= fill + link_pkg::fifo_cnt_t'(push) - link_pkg::fifo_cnt_t'(pop);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			credits <= link_pkg::credit_t'(RX_CREDITS);
		else
			credits <= credits + link_pkg::credit_t'(rx_credit) -
				link_pkg::credit_t'(pop);
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			rx_overrun <= 1'b0;
		else if (frm.rx_strobe && full)
			rx_overrun <= 1'b1;	// byte lost, only reset clears
	end

endmodule

//--- tx_credit_fifo.sv
`timescale 1ns/1ps
/*
 * tx_credit_fifo
 * Transmit byte buffer. Grants credits to the source, holds its bytes
 * and presents the head to the SPI engine.
 */
module tx_credit_fifo #(
	parameter int TX_DEPTH = 4	// power of two, 2..8
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  spi_pkg::spi_byte_t tx_data,
	input  logic               tx_valid,	// only with a credit held
	output logic               tx_credit,	// one credit per pulse
	spi_frame_if.tx_side       frm
);

	localparam int AW = $clog2(TX_DEPTH);

	spi_pkg::spi_byte_t  mem [TX_DEPTH];
	link_pkg::fifo_ptr_t wr_ptr;
	link_pkg::fifo_ptr_t rd_ptr;
	link_pkg::fifo_cnt_t fill;
	link_pkg::credit_t   pending;	// free slots not yet granted

	logic push;
	logic pop;
	logic grant;

	assign push  = tx_valid && (fill != link_pkg::fifo_cnt_t'(TX_DEPTH));
	assign pop   = frm.tx_take && (fill != '0);
	assign grant = (pending != '0) || pop;	// a popped slot is granted at once

	assign frm.tx_byte  = mem[rd_ptr[AW-1:0]];
	assign frm.tx_ready = (fill != '0);	// registered fill, write shows next cycle

	always_ff @(posedge sys_clk) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= tx_data;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 3'd1;
			if (pop)
				rd_ptr <= rd_ptr + 3'd1;
			fill <= fill + link_pkg::fifo_cnt_t'(push) - link_pkg::fifo_cnt_t'(pop);
		end
	end

	// hands out TX_DEPTH credits after reset, then one per pop
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			pending   <= link_pkg::credit_t'(TX_DEPTH);
			tx_credit <= 1'b0;
		end else begin
			tx_credit <= grant;	// lands 1 cycle after the take
			pending   <= pending + link_pkg::credit_t'(pop) -
				link_pkg::credit_t'(grant);
		end
	end

endmodule

//--- spi_stream_bridge.sv
`timescale 1ns/1ps
/*
 * spi_stream_bridge
 * SPI slave to byte stream bridge: serial engine plus side-by-side rx and
 * tx credit buffers.
 */
module spi_stream_bridge #(
	parameter bit                 CPOL       = 1'b1,	// mode 3 by default
	parameter bit                 CPHA       = 1'b1,
	parameter int                 RX_DEPTH   = 4,
	parameter int                 TX_DEPTH   = 4,
	parameter int                 RX_CREDITS = 2,
	parameter spi_pkg::spi_byte_t TX_FILL    = 8'hff
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               cs,	// spi pins
	input  logic               sclk,
	input  logic               mosi,
	output logic               miso,
	output spi_pkg::spi_byte_t rx_data,	// to sink
	output logic               rx_valid,
	input  logic               rx_credit,
	output logic               rx_overrun,
	input  spi_pkg::spi_byte_t tx_data,	// from source
	input  logic               tx_valid,
	output logic               tx_credit
);

	spi_frame_if frm ();	// per-frame byte link

	spi_slave #(
		.CPOL    (CPOL),
		.CPHA    (CPHA),
		.TX_FILL (TX_FILL)
	) spi_slave_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.frm       (frm.engine)
	);

	rx_credit_fifo #(
		.RX_DEPTH   (RX_DEPTH),
		.RX_CREDITS (RX_CREDITS)
	) rx_fifo_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.frm        (frm.rx_side),
		.rx_data    (rx_data),
		.rx_valid   (rx_valid),
		.rx_credit  (rx_credit),
		.rx_overrun (rx_overrun)
	);

	tx_credit_fifo #(
		.TX_DEPTH (TX_DEPTH)
	) tx_fifo_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_credit (tx_credit),
		.frm       (frm.tx_side)
	);

endmodule

//--- spi_stream_bridge_asserts.sv
`timescale 1ns/1ps
/*
 * spi_stream_bridge_asserts
 * Bound checker for the credit links and the overrun flag of the bridge.
 */
module spi_stream_bridge_asserts #(
	parameter int TX_DEPTH   = 4,
	parameter int RX_CREDITS = 2
) (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic rx_valid,
	input logic rx_credit,
	input logic rx_overrun,
	input logic tx_valid,
	input logic tx_credit
);

	int rx_cnt;	// sink credits as seen on the pins
	int tx_held;	// tx credits the source still holds

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			rx_cnt  <= RX_CREDITS;
			tx_held <= 0;
		end else begin
			rx_cnt  <= rx_cnt + int'(rx_credit) - int'(rx_valid);
			tx_held <= tx_held + int'(tx_credit) - int'(tx_valid);
		end
	end

	rx_valid_needs_credit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |-> (rx_cnt != 0))
		else $error("rx_valid raised with no sink credit");

	// a credit may be used in the cycle it is granted
	tx_valid_needs_credit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_valid |-> ((tx_held + int'(tx_credit)) != 0))
		else $error("tx_valid raised with no credit held");

	tx_credit_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_held <= TX_DEPTH)
		else $error("more tx credits outstanding than fifo depth");

	overrun_sticky: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!$fell(rx_overrun))
		else $error("rx_overrun cleared without reset");

	outputs_low_after_reset: assert property (@(posedge sys_clk)
		$rose(sys_rst_n) |-> (!rx_valid && !rx_overrun && !tx_credit))
		else $error("control outputs not low after reset");

endmodule

//--- tb_spi_stream_bridge.sv
`timescale 1ns/1ps
/*
 * tb_spi_stream_bridge
 * Testbench: mode 3 SPI master, credit source and sink models, order checks.
 */
module tb_spi_stream_bridge;

	localparam int SCLK_HALF = 8;	// sys_clk cycles per sclk half
	localparam int TIMEOUT   = 2000;
	localparam spi_pkg::spi_byte_t TX_FILL = 8'hff;

	logic sys_clk;
	logic sys_rst_n;
	logic cs;
	logic sclk;
	logic mosi;
	logic miso;
	spi_pkg::spi_byte_t rx_data;
	logic rx_valid;
	logic rx_credit;
	logic rx_overrun;
	spi_pkg::spi_byte_t tx_data;
	logic tx_valid;
	logic tx_credit;

	spi_pkg::spi_byte_t rx_exp[$];	// bytes of complete frames
	spi_pkg::spi_byte_t rx_got[$];	// bytes seen by the sink
	spi_pkg::spi_byte_t tx_sent[$];	// bytes pushed by the source
	logic src_en;
	logic sink_hold;
	int   src_cred;
	int   owed;	// credits the sink has not yet returned

	spi_stream_bridge dut_i (.*);

	bind spi_stream_bridge spi_stream_bridge_asserts #(
		.TX_DEPTH   (TX_DEPTH),
		.RX_CREDITS (RX_CREDITS)
	) asserts_i (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input spi_pkg::spi_byte_t got,
		input spi_pkg::spi_byte_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge sys_clk);
		#1;	// inputs move just after the edge
	endtask

	// mode 3 master, bits change on falling sclk, sampled on rising
	task automatic spi_xfer(input spi_pkg::spi_byte_t out_b, input int nbits,
		output spi_pkg::spi_byte_t in_b);
		in_b = '0;
		cs = 1'b0;
		tick(SCLK_HALF);
		for (int i = 0; i < nbits; i++) begin
			sclk = 1'b0;
			mosi = out_b[7-i];
			tick(SCLK_HALF);
			sclk = 1'b1;
			in_b = {in_b[6:0], miso};
			tick(SCLK_HALF);
		end
		cs = 1'b1;
		tick(2 * SCLK_HALF);	// engine back to idle
	endtask

	// complete frame, checks miso against the source order or the fill byte
	task automatic full_frame(input logic keep_rx, output spi_pkg::spi_byte_t got);
		spi_pkg::spi_byte_t out_b;
		spi_pkg::spi_byte_t exp;
		out_b = spi_pkg::spi_byte_t'($urandom);
		spi_xfer(out_b, 8, got);
		if (keep_rx)
			rx_exp.push_back(out_b);
		exp = (tx_sent.size() > 0) ? tx_sent.pop_front() : TX_FILL;
		check_byte("miso", got, exp);
	endtask

	task automatic wait_rx_drained();
		int t;
		t = 0;
		while (rx_got.size() != rx_exp.size()) begin
			tick(1);
			t++;
			if (t > TIMEOUT)
				fail_run("timeout waiting for received bytes at the sink");
		end
	endtask

	// source: one byte per held credit
	initial begin
		forever begin
			@(posedge sys_clk);
			#1;
			if (tx_credit)
				src_cred++;
			if (src_en && src_cred > 0) begin
				tx_valid = 1'b1;
				tx_data  = spi_pkg::spi_byte_t'($urandom);
				tx_sent.push_back(tx_data);
				src_cred--;
			end else begin
				tx_valid = 1'b0;
			end
		end
	end

	// sink: takes every byte, returns credits unless held
	initial begin
		forever begin
			@(posedge sys_clk);
			#1;
			if (rx_valid) begin
				rx_got.push_back(rx_data);
				owed++;
			end
			if (!sink_hold && owed > 0) begin
				rx_credit = 1'b1;
				owed--;
			end else begin
				rx_credit = 1'b0;
			end
		end
	end

	initial begin
		spi_pkg::spi_byte_t got;
		int base;
		int t;
		void'($urandom(32'h2b09_3630));
		cs = 1'b1;
		sclk = 1'b1;	// cpol 1 idle
		mosi = 1'b0;
		rx_credit = 1'b0;
		tx_data = '0;
		tx_valid = 1'b0;
		src_en = 1'b0;
		sink_hold = 1'b0;
		src_cred = 0;
		owed = 0;
		sys_rst_n = 1'b0;
		repeat (2) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		src_en = 1'b1;
		tick(12);	// tx fifo fills up
		for (int i = 0; i < 6; i++)
			full_frame(1'b1, got);
		spi_xfer(8'h5a, 5, got);	// aborted, no byte either way
		for (int i = 0; i < 2; i++)
			full_frame(1'b1, got);
		wait_rx_drained();
		sink_hold = 1'b1;
		base = rx_got.size();
		for (int i = 0; i < 6; i++)
			full_frame(1'b1, got);
		if (rx_overrun !== 1'b0)	// fifo just full, nothing lost yet
			fail_run($sformatf("mismatch at %0t: rx_overrun got %b expected %b",
				$time, rx_overrun, 1'b0));
		full_frame(1'b0, got);	// fifo full, dropped
		t = 0;
		while (!rx_overrun) begin
			tick(1);
			t++;
			if (t > TIMEOUT)
				fail_run("timeout waiting for rx_overrun");
		end
		if (rx_got.size() != base + 2)
			fail_run($sformatf("mismatch at %0t: rx byte count got %0d expected %0d",
				$time, rx_got.size(), base + 2));
		sink_hold = 1'b0;
		src_en = 1'b0;
		while (tx_sent.size() > 0)
			full_frame(1'b1, got);
		spi_xfer(8'hc3, 8, got);	// source stopped, tx fifo empty
		rx_exp.push_back(8'hc3);
		check_byte("miso fill", got, TX_FILL);
		wait_rx_drained();
		foreach (rx_exp[i])
			check_byte($sformatf("rx_data[%0d]", i), rx_got[i], rx_exp[i]);
		if (rx_overrun !== 1'b1) begin
			fail_run($sformatf("mismatch at %0t: rx_overrun got %b expected %b",
				$time, rx_overrun, 1'b1));
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- flist.f
spi_pkg.sv
link_pkg.sv
spi_frame_if.sv
spi_slave.sv
rx_credit_fifo.sv
tx_credit_fifo.sv
spi_stream_bridge.sv
spi_stream_bridge_asserts.sv
tb_spi_stream_bridge.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f flist.f \
	--top-module tb_spi_stream_bridge \
	-Mdir obj_dir

./obj_dir/Vtb_spi_stream_bridge | tee sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
